/* mips_pkg.sv */
package mips_pkg;

    localparam int word_width = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;

    typedef logic [word_width-1:0] word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    localparam word_t reset_vector = 32'hbfc00000;
    localparam reg_addr_t v0_index = 5'd2;
    localparam reg_addr_t ra_index = 5'd31;

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j = 6'b000010;
    localparam logic [5:0] op_jal = 6'b000011;
    localparam logic [5:0] op_beq = 6'b000100;
    localparam logic [5:0] op_bne = 6'b000101;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_slti = 6'b001010;
    localparam logic [5:0] op_sltiu = 6'b001011;
    localparam logic [5:0] op_andi = 6'b001100;
    localparam logic [5:0] op_ori = 6'b001101;
    localparam logic [5:0] op_xori = 6'b001110;
    localparam logic [5:0] op_lui = 6'b001111;
    localparam logic [5:0] op_lw = 6'b100011;
    localparam logic [5:0] op_sw = 6'b101011;

    // function field of special
    localparam logic [5:0] fn_sll = 6'b000000;
    localparam logic [5:0] fn_srl = 6'b000010;
    localparam logic [5:0] fn_sra = 6'b000011;
    localparam logic [5:0] fn_jr = 6'b001000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and = 6'b100100;
    localparam logic [5:0] fn_or = 6'b100101;
    localparam logic [5:0] fn_xor = 6'b100110;
    localparam logic [5:0] fn_slt = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

endpackage

/* mips_dec_if.sv */
`timescale 1ns/1ps

interface mips_dec_if import mips_pkg::*; ();

    alu_op_t alu_op;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    logic [4:0] shamt;
    // extended as the opcode requires
    word_t imm_ext;
    logic use_imm;
    logic reg_write;
    logic is_load;
    logic is_store;
    logic is_beq;
    logic is_bne;
    logic is_jump_imm;
    logic [25:0] jump_index;
    logic is_jump_reg;
    logic is_link;

    modport decode (
        output alu_op, rs, rt, dest, shamt, imm_ext, use_imm, reg_write,
        output is_load, is_store, is_beq, is_bne, is_jump_imm, jump_index,
        output is_jump_reg, is_link
    );

    modport execute (
        input alu_op, rs, rt, dest, shamt, imm_ext, use_imm, reg_write,
        input is_load, is_store, is_beq, is_bne, is_jump_imm, jump_index,
        input is_jump_reg, is_link
    );

endinterface

/* mips_reg_if.sv */
`timescale 1ns/1ps

interface mips_reg_if import mips_pkg::*; ();

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t rs_data;
    word_t rt_data;
    logic wr_en;
    reg_addr_t wr_addr;
    word_t wr_data;

    modport regfile (
        input rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        output rs_data, rt_data
    );

    modport user (
        output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        input rs_data, rt_data
    );

endinterface

/* mips_fetch.sv */
`timescale 1ns/1ps

module mips_fetch import mips_pkg::*; (
    input logic clk,
    input logic reset,
    input logic clk_enable,
    input logic redirect,
    input word_t redirect_target,
    output word_t pc,
    output word_t pc_plus8,
    output logic step,
    output logic active
);

    logic pending;
    word_t pending_target;

    assign pc_plus8 = pc + 32'd8;
    // address zero is the halt point
    assign step = active && clk_enable && (pc != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
            pending <= 1'b0;
            active <= 1'b1;
        end else begin
            if (active && clk_enable && pc == '0) begin
                active <= 1'b0;
            end
            if (step) begin
                // delay slot done, take the stored target
                if (pending) begin
                    pc <= pending_target;
                end else begin
                    pc <= pc + 32'd4;
                end
                pending <= redirect;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && redirect) begin
            pending_target <= redirect_target;
        end
    end

endmodule

/* mips_decode.sv */
`timescale 1ns/1ps

module mips_decode import mips_pkg::*; (
    input word_t instr,
    mips_dec_if.decode dec
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm;
    logic zero_ext;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign imm = instr[15:0];

    assign dec.rs = instr[25:21];
    assign dec.rt = instr[20:16];
    assign dec.shamt = instr[10:6];
    assign dec.jump_index = instr[25:0];

    // logical immediates are zero extended
    assign zero_ext = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
    assign dec.imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb begin
        dec.alu_op = alu_add;
        dec.dest = instr[20:16];
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b0;
        dec.is_load = 1'b0;
        dec.is_store = 1'b0;
        dec.is_beq = 1'b0;
        dec.is_bne = 1'b0;
        dec.is_jump_imm = 1'b0;
        dec.is_jump_reg = 1'b0;
        dec.is_link = 1'b0;
        case (opcode)
            op_special: begin
                dec.dest = instr[15:11];
                dec.use_imm = 1'b0;
                dec.reg_write = 1'b1;
                case (funct)
                    fn_sll: dec.alu_op = alu_sll;
                    fn_srl: dec.alu_op = alu_srl;
                    fn_sra: dec.alu_op = alu_sra;
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and: dec.alu_op = alu_and;
                    fn_or: dec.alu_op = alu_or;
                    fn_xor: dec.alu_op = alu_xor;
                    fn_slt: dec.alu_op = alu_slt;
                    fn_sltu: dec.alu_op = alu_sltu;
                    fn_jr: begin
                        dec.reg_write = 1'b0;
                        dec.is_jump_reg = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            op_j: dec.is_jump_imm = 1'b1;
            op_jal: begin
                dec.is_jump_imm = 1'b1;
                dec.is_link = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest = ra_index;
            end
            op_beq: dec.is_beq = 1'b1;
            op_bne: dec.is_bne = 1'b1;
            op_addiu: dec.reg_write = 1'b1;
            op_slti: begin
                dec.alu_op = alu_slt;
                dec.reg_write = 1'b1;
            end
            // unsigned compare, sign-extended immediate
            op_sltiu: begin
                dec.alu_op = alu_sltu;
                dec.reg_write = 1'b1;
            end
            op_andi: begin
                dec.alu_op = alu_and;
                dec.reg_write = 1'b1;
            end
            op_ori: begin
                dec.alu_op = alu_or;
                dec.reg_write = 1'b1;
            end
            op_xori: begin
                dec.alu_op = alu_xor;
                dec.reg_write = 1'b1;
            end
            op_lui: begin
                dec.alu_op = alu_lui;
                dec.reg_write = 1'b1;
            end
            op_lw: begin
                dec.is_load = 1'b1;
                dec.reg_write = 1'b1;
            end
            op_sw: dec.is_store = 1'b1;
            default: dec.use_imm = 1'b0;
        endcase
    end

endmodule

/* mips_execute.sv */
`timescale 1ns/1ps

module mips_execute import mips_pkg::*; (
    mips_dec_if.execute dec,
    mips_reg_if.user rf,
    input word_t pc,
    input word_t pc_plus8,
    input logic step,
    input word_t data_readdata,
    output word_t data_address,
    output word_t data_writedata,
    output logic data_write,
    output logic data_read,
    output logic redirect,
    output word_t redirect_target
);

    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t pc_plus4;
    logic lt_signed;
    logic lt_unsigned;
    logic operands_equal;
    logic branch_taken;

    assign rf.rs_addr = dec.rs;
    assign rf.rt_addr = dec.rt;

    assign op_a = rf.rs_data;
    assign op_b = dec.use_imm ? dec.imm_ext : rf.rt_data;

    assign lt_signed = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (dec.alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or: alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = {{(word_width-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(word_width-1){1'b0}}, lt_unsigned};
            // shifts take rt and the shamt field
            alu_sll: alu_result = rf.rt_data << dec.shamt;
            alu_srl: alu_result = rf.rt_data >> dec.shamt;
            alu_sra: alu_result = $signed(rf.rt_data) >>> dec.shamt;
            alu_lui: alu_result = {op_b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    // word accesses only
    assign data_address = rf.rs_data + dec.imm_ext;
    assign data_writedata = rf.rt_data;
    assign data_write = step && dec.is_store;
    assign data_read = step && dec.is_load;

    assign pc_plus4 = pc + 32'd4;
    assign operands_equal = rf.rs_data == rf.rt_data;
    assign branch_taken = (dec.is_beq && operands_equal) || (dec.is_bne && !operands_equal);

    assign redirect = step && (branch_taken || dec.is_jump_imm || dec.is_jump_reg);

    always_comb begin
        if (dec.is_jump_reg) begin
            redirect_target = rf.rs_data;
        end else if (dec.is_jump_imm) begin
            redirect_target = {pc_plus4[31:28], dec.jump_index, 2'b00};
        end else begin
            redirect_target = pc_plus4 + {dec.imm_ext[29:0], 2'b00};
        end
    end

    assign rf.wr_en = step && dec.reg_write;
    assign rf.wr_addr = dec.dest;

    always_comb begin
        if (dec.is_link) begin
            rf.wr_data = pc_plus8;
        end else if (dec.is_load) begin
            rf.wr_data = data_readdata;
        end else begin
            rf.wr_data = alu_result;
        end
    end

endmodule

/* mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*; (
    input logic clk,
    input logic reset,
    mips_reg_if.regfile rf,
    output word_t register_v0
);

    word_t regs [reg_count];

    assign rf.rs_data = regs[rf.rs_addr];
    assign rf.rt_data = regs[rf.rt_addr];

    assign register_v0 = regs[v0_index];

    // register zero keeps its reset value and so reads as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.wr_addr != '0) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

endmodule

/* mips_cpu_harvard.sv */
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
    input logic clk,
    input logic reset,
    output logic active,
    output logic [31:0] register_v0,
    input logic clk_enable,
    output logic [31:0] instr_address,
    input logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic data_write,
    output logic data_read,
    output logic [31:0] data_writedata,
    input logic [31:0] data_readdata
);

    word_t pc;
    word_t pc_plus8;
    logic step;
    logic redirect;
    word_t redirect_target;

    mips_dec_if dec_bus ();
    mips_reg_if reg_bus ();

    assign instr_address = pc;

    mips_fetch fetch0 (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .redirect(redirect),
        .redirect_target(redirect_target),
        .pc(pc),
        .pc_plus8(pc_plus8),
        .step(step),
        .active(active)
    );

    mips_decode decode0 (
        .instr(instr_readdata),
        .dec(dec_bus.decode)
    );

    mips_execute execute0 (
        .dec(dec_bus.execute),
        .rf(reg_bus.user),
        .pc(pc),
        .pc_plus8(pc_plus8),
        .step(step),
        .data_readdata(data_readdata),
        .data_address(data_address),
        .data_writedata(data_writedata),
        .data_write(data_write),
        .data_read(data_read),
        .redirect(redirect),
        .redirect_target(redirect_target)
    );

    mips_regfile regfile0 (
        .clk(clk),
        .reset(reset),
        .rf(reg_bus.regfile),
        .register_v0(register_v0)
    );

endmodule

/* mips_cpu_harvard_assert.sv */
`timescale 1ns/1ps

module mips_cpu_harvard_assert (
    input logic clk,
    input logic reset,
    input logic active,
    input logic data_write,
    input logic data_read,
    input logic [31:0] instr_address
);

    // one data access per cycle at most
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(data_write && data_read)
    ) else $error("data_write and data_read high together");

    idle_when_halted: assert property (
        @(posedge clk) disable iff (reset) !active |-> (!data_write && !data_read)
    ) else $error("data strobe while the CPU is inactive");

    fetch_aligned: assert property (
        @(posedge clk) disable iff (reset) active |-> (instr_address[1:0] == 2'b00)
    ) else $error("instr_address not word aligned");

endmodule

bind mips_cpu_harvard mips_cpu_harvard_assert assert0 (
    .clk(clk),
    .reset(reset),
    .active(active),
    .data_write(data_write),
    .data_read(data_read),
    .instr_address(instr_address)
);

/* mips_cpu_harvard_tb.sv */
`timescale 1ns/1ps

module mips_cpu_harvard_tb import mips_pkg::*; ();

    localparam reg_addr_t reg_zero = 5'd0;
    localparam reg_addr_t reg_a = 5'd8;
    localparam reg_addr_t reg_b = 5'd9;
    localparam int alu_kinds = 17;

    logic clk;
    logic reset;
    logic clk_enable;
    logic active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic data_write;
    logic data_read;
    word_t data_writedata;
    word_t data_readdata;

    word_t imem [64];
    word_t dmem [64];
    word_t imem_offset;
    logic [5:0] prog_len;
    logic stepping;
    logic stall_on;
    logic monitor_on;
    word_t read_strobes;
    integer seed;

    mips_cpu_harvard dut0 (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .clk_enable(clk_enable),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_read(data_read),
        .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    always #2 clk = ~clk;

    // program sits at the reset vector, everything else reads as nop
    assign imem_offset = instr_address - reset_vector;
    assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : 32'h0;
    assign data_readdata = dmem[data_address[7:2]];

    always @(posedge clk) begin
        if (data_write === 1'b1) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    always @(posedge clk) begin
        clk_enable <= stall_on ? rand_bit() : 1'b1;
    end

    assign stepping = active && clk_enable && (instr_address != 32'h0);

    // data strobes must follow the opcode being stepped
    always @(negedge clk) begin
        if (monitor_on) begin
            check("data_read", {31'd0, data_read},
                {31'd0, stepping && (instr_readdata[31:26] == op_lw)});
            check("data_write", {31'd0, data_write},
                {31'd0, stepping && (instr_readdata[31:26] == op_sw)});
            if (active) begin
                check("instr_address low bits", {30'd0, instr_address[1:0]}, 32'd0);
            end
            if (data_read) begin
                read_strobes = read_strobes + 32'd1;
            end
        end
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic logic rand_bit();
        word_t r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic word_t r_type(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                     reg_addr_t rd, logic [4:0] sh);
        return {op_special, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(logic [5:0] op, word_t target);
        return {op, target[27:2]};
    endfunction

    function automatic word_t addiu_v0(logic [15:0] imm);
        return i_type(op_addiu, v0_index, v0_index, imm);
    endfunction

    function automatic word_t alu_instr(int kind, logic [15:0] imm, logic [4:0] sh);
        case (kind)
            0: return r_type(fn_addu, reg_a, reg_b, v0_index, 5'd0);
            1: return r_type(fn_subu, reg_a, reg_b, v0_index, 5'd0);
            2: return r_type(fn_and, reg_a, reg_b, v0_index, 5'd0);
            3: return r_type(fn_or, reg_a, reg_b, v0_index, 5'd0);
            4: return r_type(fn_xor, reg_a, reg_b, v0_index, 5'd0);
            5: return r_type(fn_slt, reg_a, reg_b, v0_index, 5'd0);
            6: return r_type(fn_sltu, reg_a, reg_b, v0_index, 5'd0);
            7: return r_type(fn_sll, reg_zero, reg_b, v0_index, sh);
            8: return r_type(fn_srl, reg_zero, reg_b, v0_index, sh);
            9: return r_type(fn_sra, reg_zero, reg_b, v0_index, sh);
            10: return i_type(op_addiu, reg_a, v0_index, imm);
            11: return i_type(op_andi, reg_a, v0_index, imm);
            12: return i_type(op_ori, reg_a, v0_index, imm);
            13: return i_type(op_xori, reg_a, v0_index, imm);
            14: return i_type(op_lui, reg_zero, v0_index, imm);
            15: return i_type(op_slti, reg_a, v0_index, imm);
            16: return i_type(op_sltiu, reg_a, v0_index, imm);
            default: return 32'h0;
        endcase
    endfunction

    // expected v0 for one operation, from the MIPS-I rules
    function automatic word_t alu_ref(int kind, word_t a, word_t b, logic [15:0] imm,
                                      logic [4:0] sh);
        word_t sext;
        word_t zext;
        word_t res;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (kind)
            0: res = a + b;
            1: res = a - b;
            2: res = a & b;
            3: res = a | b;
            4: res = a ^ b;
            5: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: res = (a < b) ? 32'd1 : 32'd0;
            7: res = b << sh;
            8: res = b >> sh;
            9: begin
                res = b >> sh;
                // refill the vacated top bits with the sign
                if (b[31]) begin
                    res = res | ~(32'hffffffff >> sh);
                end
            end
            10: res = a + sext;
            11: res = a & zext;
            12: res = a | zext;
            13: res = a ^ zext;
            14: res = {imm, 16'h0000};
            15: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            16: res = (a < sext) ? 32'd1 : 32'd0;
            default: res = 32'h0;
        endcase
        return res;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                $time, what, got, expected));
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = 32'h0;
        end
        prog_len = 6'd0;
    endtask

    task automatic clear_data();
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] <= 32'h0;
        end
    endtask

    task automatic emit(input word_t instr);
        imem[prog_len] = instr;
        prog_len = prog_len + 6'd1;
    endtask

    task automatic load_const(input reg_addr_t r, input word_t value);
        emit(i_type(op_lui, reg_zero, r, value[31:16]));
        emit(i_type(op_ori, r, r, value[15:0]));
    endtask

    // jump to address zero with a nop in the delay slot
    task automatic emit_halt();
        emit(r_type(fn_jr, reg_zero, reg_zero, reg_zero, 5'd0));
        emit(32'h0);
    endtask

    task automatic run_program();
        int cycles;
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        monitor_on = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (active === 1'b1 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b0) begin
            abort_run("timeout: the CPU never halted within 200 cycles");
        end
    endtask

    task automatic run_alu_ops(input int rounds);
        word_t a;
        word_t b;
        word_t r;
        for (int round = 0; round < rounds; round++) begin
            for (int kind = 0; kind < alu_kinds; kind++) begin
                a = rand_word();
                b = rand_word();
                r = rand_word();
                clear_program();
                load_const(reg_a, a);
                load_const(reg_b, b);
                emit(alu_instr(kind, r[15:0], r[20:16]));
                emit_halt();
                run_program();
                check($sformatf("alu kind %0d", kind), register_v0,
                    alu_ref(kind, a, b, r[15:0], r[20:16]));
            end
        end
    endtask

    task automatic run_store_load();
        word_t value;
        word_t r;
        logic [15:0] offset;
        value = rand_word();
        r = rand_word();
        offset = {8'h00, r[5:0], 2'b00};
        clear_data();
        clear_program();
        load_const(reg_a, value);
        emit(i_type(op_sw, reg_zero, reg_a, offset));
        emit(i_type(op_lw, reg_zero, v0_index, offset));
        emit_halt();
        read_strobes = 32'd0;
        run_program();
        check("stored word", dmem[r[5:0]], value);
        check("loaded word", register_v0, value);
        check("data_read strobes", read_strobes, 32'd1);
    endtask

    task automatic run_branches(input logic equal_ops);
        word_t expected;
        clear_program();
        emit(i_type(op_addiu, reg_zero, reg_a, 16'd5));
        emit(i_type(op_addiu, reg_zero, reg_b, equal_ops ? 16'd5 : 16'd6));
        emit(i_type(op_addiu, reg_zero, v0_index, 16'd0));
        emit(i_type(op_beq, reg_a, reg_b, 16'd2));
        emit(addiu_v0(16'd1));
        emit(addiu_v0(16'd2));
        emit(addiu_v0(16'd4));
        emit(i_type(op_bne, reg_a, reg_b, 16'd2));
        emit(addiu_v0(16'd8));
        emit(addiu_v0(16'd16));
        emit(addiu_v0(16'd32));
        emit_halt();
        run_program();
        // delay slots and targets always run, a taken branch skips one word
        expected = 32'd1 + 32'd4 + 32'd8 + 32'd32 + (equal_ops ? 32'd16 : 32'd2);
        check("branch sum", register_v0, expected);
    endtask

    task automatic run_jal();
        word_t jal_addr;
        word_t sub_addr;
        jal_addr = reset_vector + 32'd4;
        sub_addr = reset_vector + 32'd20;
        clear_program();
        emit(i_type(op_addiu, reg_zero, v0_index, 16'd0));
        emit(j_type(op_jal, sub_addr));
        emit(32'h0);
        emit_halt();
        // subroutine copies the link register
        emit(r_type(fn_addu, ra_index, reg_zero, v0_index, 5'd0));
        emit(r_type(fn_jr, ra_index, reg_zero, reg_zero, 5'd0));
        emit(32'h0);
        run_program();
        check("link address", register_v0, jal_addr + 32'd8);
    endtask

    task automatic run_stall_and_halt();
        word_t v0_at_halt;
        stall_on = 1'b1;
        run_alu_ops(1);
        v0_at_halt = register_v0;
        for (int cycles = 0; cycles < 20; cycles++) begin
            @(negedge clk);
            check("active after halt", {31'd0, active}, 32'd0);
            check("data_write after halt", {31'd0, data_write}, 32'd0);
            check("register_v0 after halt", register_v0, v0_at_halt);
        end
        stall_on = 1'b0;
    endtask

    initial begin
        seed = 79;
        clk = 1'b0;
        reset <= 1'b1;
        clk_enable <= 1'b1;
        stall_on = 1'b0;
        monitor_on = 1'b0;
        read_strobes = 32'd0;
        clear_program();
        clear_data();
        run_alu_ops(2);
        run_store_load();
        run_branches(1'b1);
        run_branches(1'b0);
        run_jal();
        run_stall_and_halt();
        $display("Everything OK");
        $finish;
    end

endmodule

/* mips_cpu_harvard.f */
mips_pkg.sv
mips_dec_if.sv
mips_reg_if.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_regfile.sv
mips_cpu_harvard.sv
mips_cpu_harvard_assert.sv
mips_cpu_harvard_tb.sv

/* Makefile */
TOP = mips_cpu_harvard_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_cpu_harvard.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
